/* Makefile */
VERILATOR  ?= verilator
SIM_FLAGS  ?= --binary --timing -Wno-fatal -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
TOP        ?= tb_lsu
RTL_TOP    ?= lsu_top
FILELIST   ?= sources.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$($(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* common/lsu_params.svh */
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

////////////////////////////////////////
// load/store unit sizing
////////////////////////////////////////

// data and address width of the bus
`define LSU_DATA_W 32

// byte enables per bus word
`define LSU_BE_W 4

// max bus transactions in flight
`define LSU_MAX_OUTSTANDING 2

// outstanding counter width, must hold LSU_MAX_OUTSTANDING
`define LSU_CNT_W 2

`endif

/* common/lsu_pkg.sv */
`default_nettype none

`include "lsu_params.svh"

package lsu_pkg;

  // access size, 11 decodes as byte too
  typedef enum logic [1:0] {
    LSU_SIZE_WORD    = 2'b00,
    LSU_SIZE_HALF    = 2'b01,
    LSU_SIZE_BYTE    = 2'b10,
    LSU_SIZE_BYTE_HI = 2'b11
  } lsu_size_e;

  // load extension mode
  typedef enum logic [1:0] {
    LSU_EXT_ZERO    = 2'b00,
    LSU_EXT_SIGN    = 2'b01,
    LSU_EXT_ONE     = 2'b10,
    LSU_EXT_SIGN_HI = 2'b11 // sign extend as well
  } lsu_ext_e;

  // request from the execute stage
  typedef struct packed {
    logic                   we;           // store when set
    lsu_size_e              size;
    lsu_ext_e               ext;
    logic [1:0]             reg_offset;   // byte offset of store data in register
    logic [`LSU_DATA_W-1:0] wdata;
    logic [`LSU_DATA_W-1:0] op_a;
    logic [`LSU_DATA_W-1:0] op_b;
    logic                   use_incr;     // address is a + b
    logic                   second_phase; // repeat of a crossing access
  } lsu_ex_req_t;

  // bus address phase
  typedef struct packed {
    logic [`LSU_DATA_W-1:0] addr;
    logic                   we;
    logic [`LSU_BE_W-1:0]   be;
    logic [`LSU_DATA_W-1:0] wdata;
  } lsu_bus_req_t;

  // kept per accepted access for the result stage
  typedef struct packed {
    lsu_size_e  size;
    logic [1:0] offset; // byte offset of the access
    lsu_ext_e   ext;
    logic       we;
  } lsu_wb_ctrl_t;

endpackage

`default_nettype wire

/* hw/lsu_load_align.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lsu_params.svh"

module lsu_load_align (
  input  wire logic                         clk,
  input  wire logic                         rst_n,
  input  wire logic                         ctrl_update_i,
  input  wire logic                         data_rvalid_i,
  input  wire logic                         second_phase_i,
  input  wire logic                         data_misaligned_i,
  input  wire lsu_pkg::lsu_wb_ctrl_t        wb_ctrl_i,
  input  wire logic [`LSU_DATA_W-1:0]       data_rdata_i,
  output logic [`LSU_DATA_W-1:0]            data_rdata_ex_o
);

  lsu_pkg::lsu_wb_ctrl_t    ctrl_q;   // control of the access waiting for data
  logic [`LSU_DATA_W-1:0]   rdata_q;  // last result, or first half of a crossing load
  logic                     crossing; // access spans two words
  logic [2*`LSU_DATA_W-1:0] window;   // bus word with hold or itself above it
  logic [`LSU_DATA_W-1:0]   field;    // data starting at the access offset
  logic                     fill;     // extension bit
  logic [`LSU_DATA_W-1:0]   rdata_ext;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_q <= '0;
    end else if (ctrl_update_i) begin
      ctrl_q <= wb_ctrl_i;
    end
  end

  ////////////////////////////////////////
  // alignment
  ////////////////////////////////////////

  assign crossing = ((ctrl_q.size == lsu_pkg::LSU_SIZE_WORD) && (ctrl_q.offset != 2'b00)) ||
                    ((ctrl_q.size == lsu_pkg::LSU_SIZE_HALF) && (ctrl_q.offset == 2'b11));

  // crossing: upper bytes from the new word, lower bytes from the hold register
  assign window = crossing ? {data_rdata_i, rdata_q} : {data_rdata_i, data_rdata_i};
  assign field  = window[{ctrl_q.offset, 3'b000} +: `LSU_DATA_W];

  ////////////////////////////////////////
  // extension
  ////////////////////////////////////////

  always_comb begin
    case (ctrl_q.ext)
      lsu_pkg::LSU_EXT_ZERO: fill = 1'b0;
      lsu_pkg::LSU_EXT_ONE:  fill = 1'b1;
      lsu_pkg::LSU_EXT_SIGN, lsu_pkg::LSU_EXT_SIGN_HI: begin
        // msb of the selected field
        fill = (ctrl_q.size == lsu_pkg::LSU_SIZE_HALF) ? field[15] : field[7];
      end
      default: fill = 1'b0;
    endcase
  end

  always_comb begin
    case (ctrl_q.size)
      lsu_pkg::LSU_SIZE_WORD: rdata_ext = field;                          // nothing to extend
      lsu_pkg::LSU_SIZE_HALF: rdata_ext = {{(`LSU_DATA_W-16){fill}}, field[15:0]};
      default:                rdata_ext = {{(`LSU_DATA_W-8){fill}}, field[7:0]}; // byte
    endcase
  end

  // raw word kept for the second half, else the final value
  always_ff @(posedge clk) begin
    if (data_rvalid_i && !ctrl_q.we) begin
      if (second_phase_i || data_misaligned_i) rdata_q <= data_rdata_i;
      else                                     rdata_q <= rdata_ext;
    end
  end

  assign data_rdata_ex_o = data_rvalid_i ? rdata_ext : rdata_q;

endmodule

`default_nettype wire

/* hw/lsu_store_align.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lsu_params.svh"

module lsu_store_align (
  input  wire lsu_pkg::lsu_ex_req_t  ex_req_i,
  input  wire logic                  data_req_ex_i,
  output lsu_pkg::lsu_bus_req_t      bus_req_o,
  output lsu_pkg::lsu_wb_ctrl_t      wb_ctrl_o,
  output logic                       data_misaligned_o
);

  logic [`LSU_DATA_W-1:0]   addr;      // effective address
  logic [1:0]               offset;    // byte within word
  logic                     second;    // second half of a crossing access
  logic [`LSU_BE_W-1:0]     be;
  logic [1:0]               rot;       // store rotation in bytes
  logic [2*`LSU_DATA_W-1:0] wdata_dbl; // store data twice, for rotation

  ////////////////////////////////////////
  // address
  ////////////////////////////////////////

  assign addr   = ex_req_i.use_incr ? (ex_req_i.op_a + ex_req_i.op_b) : ex_req_i.op_a;
  assign offset = addr[1:0];
  assign second = ex_req_i.second_phase;

  ////////////////////////////////////////
  // byte enables
  ////////////////////////////////////////

  always_comb begin
    be = '0;
    case (ex_req_i.size)
      lsu_pkg::LSU_SIZE_WORD: begin
        if (second) be = (`LSU_BE_W'(1) << offset) - `LSU_BE_W'(1); // bytes below offset
        else        be = {`LSU_BE_W{1'b1}} << offset;                // offset up to byte 3
      end
      lsu_pkg::LSU_SIZE_HALF: begin
        if (second) be = `LSU_BE_W'(1);         // spill byte lands in byte 0
        else        be = `LSU_BE_W'(3) << offset; // shift clips at byte 3
      end
      lsu_pkg::LSU_SIZE_BYTE, lsu_pkg::LSU_SIZE_BYTE_HI: begin
        be = `LSU_BE_W'(1) << offset;
      end
      default: be = '0;
    endcase
  end

  ////////////////////////////////////////
  // store data rotation
  ////////////////////////////////////////

  // rotate left by (addr offset - register offset) bytes
  assign rot       = offset - ex_req_i.reg_offset;
  assign wdata_dbl = {ex_req_i.wdata, ex_req_i.wdata};

  // bus request, second phase goes to the aligned next word
  assign bus_req_o.addr  = second ? {addr[`LSU_DATA_W-1:2], 2'b00} : addr;
  assign bus_req_o.we    = ex_req_i.we;
  assign bus_req_o.be    = be;
  assign bus_req_o.wdata = wdata_dbl[(2*`LSU_DATA_W-1) - {rot, 3'b000} -: `LSU_DATA_W];

  // control for load alignment in the result stage
  assign wb_ctrl_o.size   = ex_req_i.size;
  assign wb_ctrl_o.offset = offset;
  assign wb_ctrl_o.ext    = ex_req_i.ext;
  assign wb_ctrl_o.we     = ex_req_i.we;

  ////////////////////////////////////////
  // crossing detection
  ////////////////////////////////////////

  always_comb begin
    data_misaligned_o = 1'b0;
    if (data_req_ex_i && !second) begin
      case (ex_req_i.size)
        lsu_pkg::LSU_SIZE_WORD: data_misaligned_o = (offset != 2'b00);
        lsu_pkg::LSU_SIZE_HALF: data_misaligned_o = (offset == 2'b11); // top byte spills
        default:                data_misaligned_o = 1'b0;              // bytes never cross
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/lsu_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lsu_params.svh"

module lsu_top (
  input  wire logic                   clk,
  input  wire logic                   rst_n,

  // execute side
  input  wire logic                   data_req_ex_i,
  input  wire lsu_pkg::lsu_ex_req_t   ex_req_i,
  output logic [`LSU_DATA_W-1:0]      data_rdata_ex_o,
  output logic                        data_misaligned_o,
  output logic                        lsu_ready_ex_o,
  output logic                        lsu_ready_wb_o,
  output logic                        busy_o,

  // data bus
  output logic                        data_req_o,
  output lsu_pkg::lsu_bus_req_t       bus_o,
  input  wire logic                   data_gnt_i,
  input  wire logic                   data_rvalid_i,
  input  wire logic [`LSU_DATA_W-1:0] data_rdata_i
);

  lsu_pkg::lsu_wb_ctrl_t wb_ctrl; // control of the request in ex
  logic                  ctrl_update;

  ////////////////////////////////////////
  // stages
  ////////////////////////////////////////

  lsu_store_align u_store_align (
    .ex_req_i          (ex_req_i),
    .data_req_ex_i     (data_req_ex_i),
    .bus_req_o         (bus_o),             // straight to the bus
    .wb_ctrl_o         (wb_ctrl),
    .data_misaligned_o (data_misaligned_o)
  );

  lsu_trans_ctrl u_trans_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_req_ex_i  (data_req_ex_i),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_req_o     (data_req_o),
    .lsu_ready_ex_o (lsu_ready_ex_o),
    .lsu_ready_wb_o (lsu_ready_wb_o),
    .busy_o         (busy_o),
    .ctrl_update_o  (ctrl_update)
  );

  lsu_load_align u_load_align (
    .clk               (clk),
    .rst_n             (rst_n),
    .ctrl_update_i     (ctrl_update),
    .data_rvalid_i     (data_rvalid_i),
    .second_phase_i    (ex_req_i.second_phase),
    .data_misaligned_i (data_misaligned_o),
    .wb_ctrl_i         (wb_ctrl),
    .data_rdata_i      (data_rdata_i),
    .data_rdata_ex_o   (data_rdata_ex_o)
  );

endmodule

`default_nettype wire

/* hw/lsu_trans_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lsu_params.svh"

module lsu_trans_ctrl (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic data_req_ex_i,
  input  wire logic data_gnt_i,
  input  wire logic data_rvalid_i,
  output logic      data_req_o,
  output logic      lsu_ready_ex_o,
  output logic      lsu_ready_wb_o,
  output logic      busy_o,
  output logic      ctrl_update_o
);

  logic [`LSU_CNT_W-1:0] cnt_q;    // transfers granted and not yet answered
  logic [`LSU_CNT_W-1:0] cnt_d;
  logic                  accepted; // req and gnt in the same cycle

  // no new request while the limit is reached
  assign data_req_o = data_req_ex_i && (cnt_q < `LSU_MAX_OUTSTANDING);
  assign accepted   = data_req_o && data_gnt_i;

  always_comb begin
    cnt_d = cnt_q;
    case ({accepted, data_rvalid_i})
      2'b10:   cnt_d = cnt_q + `LSU_CNT_W'(1);
      2'b01:   cnt_d = cnt_q - `LSU_CNT_W'(1);
      default: cnt_d = cnt_q; // none, or one in and one out
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  ////////////////////////////////////////
  // ready and busy
  ////////////////////////////////////////

  // wb stage free when empty, else when its response arrives
  assign lsu_ready_wb_o = (cnt_q == '0) ? 1'b1 : data_rvalid_i;

  always_comb begin
    if (!data_req_ex_i) begin
      lsu_ready_ex_o = 1'b1;                          // nothing to do
    end else begin
      case (cnt_q)
        `LSU_CNT_W'(0): lsu_ready_ex_o = accepted;
        `LSU_CNT_W'(1): lsu_ready_ex_o = accepted && data_rvalid_i; // ex and wb in lock step
        default:        lsu_ready_ex_o = data_rvalid_i;
      endcase
    end
  end

  assign ctrl_update_o = lsu_ready_ex_o && data_req_ex_i; // request moves on to wb
  assign busy_o        = (cnt_q != '0) || data_req_o;

endmodule

`default_nettype wire

/* sources.f */
+incdir+common
common/lsu_pkg.sv
hw/lsu_store_align.sv
hw/lsu_trans_ctrl.sv
hw/lsu_load_align.sv
hw/lsu_top.sv
tests/lsu_checker.sv
tests/tb_lsu.sv

/* tests/lsu_checker.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lsu_params.svh"

module lsu_checker (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   data_req_ex_i,
  input  wire lsu_pkg::lsu_ex_req_t   ex_req_i,
  input  wire logic [`LSU_DATA_W-1:0] rdata_ex_i,
  input  wire logic                   misaligned_i,
  input  wire logic                   ready_ex_i,
  input  wire logic                   ready_wb_i,
  input  wire logic                   busy_i,
  input  wire logic                   data_req_i,
  input  wire lsu_pkg::lsu_bus_req_t  bus_i,
  input  wire logic                   data_gnt_i,
  input  wire logic                   data_rvalid_i,
  output int                          bus_errs_o,
  output int                          load_errs_o,
  output int                          ctrl_errs_o,
  output int                          loads_checked_o
);

  logic [31:0] mem [64];  // reference copy of the bus memory
  logic        chk_q [$]; // response carries a checkable load result
  logic [31:0] exp_q [$];
  int          cnt = 0;   // grants minus responses
  int          bus_errs = 0;
  int          load_errs = 0;
  int          ctrl_errs = 0;
  int          loads_checked = 0;
  logic        was_reset = 1'b1;
  logic [31:0] first_word; // first half of a crossing load
  logic [1:0]  first_off;
  logic [1:0]  first_size;
  logic [1:0]  first_ext;

  assign bus_errs_o      = bus_errs;
  assign load_errs_o     = load_errs;
  assign ctrl_errs_o     = ctrl_errs;
  assign loads_checked_o = loads_checked;

  initial begin
    for (int i = 0; i < 64; i++) mem[i] = (i * 32'h0101_0101) ^ 32'h5A3C_96E1 ^ (i << 20);
  end

  ////////////////////////////////////////
  // reference rules
  ////////////////////////////////////////

  // pair holds the next word above the access word
  function automatic logic [31:0] load_value(logic [63:0] pair, logic [1:0] off,
                                             logic [1:0] size, logic [1:0] ext);
    logic [31:0] raw;
    logic        fill;
    raw  = pair[8*off +: 32];
    fill = (ext == 2'b00) ? 1'b0 : (ext == 2'b10) ? 1'b1 : (size == 2'b01 ? raw[15] : raw[7]);
    case (size)
      2'b00:   return raw;
      2'b01:   return {{16{fill}}, raw[15:0]};
      default: return {{24{fill}}, raw[7:0]};
    endcase
  endfunction

  function automatic logic [3:0] expected_be(logic [1:0] size, logic [1:0] off, logic second);
    logic [3:0] be;
    for (int b = 0; b < 4; b++) begin
      case (size)
        2'b00:   be[b] = second ? (b < off) : (b >= off);
        2'b01:   be[b] = second ? (b == 0) : (b == off || b == off + 1); // clipped at byte 3
        default: be[b] = (b == off);
      endcase
    end
    return be;
  endfunction

  function automatic logic [31:0] rotate_store(logic [31:0] d, logic [1:0] rot);
    logic [31:0] r;
    for (int j = 0; j < 4; j++) r[8*j +: 8] = d[8*((j - rot) & 3) +: 8];
    return r;
  endfunction

  ////////////////////////////////////////
  // checks on every edge
  ////////////////////////////////////////

  always @(posedge clk) begin
    logic [1:0]  size;
    logic [1:0]  off;
    logic [31:0] eff;
    logic [31:0] exp_addr;
    logic [31:0] exp_wdata;
    logic [3:0]  exp_be;
    logic        second;
    logic        exp_mis;
    logic        exp_req;
    logic        exp_acc;
    logic        exp_rdy;
    logic        chk;
    logic [31:0] exp_val;
    logic [5:0]  idx;
    if (!rst_n || was_reset) begin // in reset and the first edge after it
      if (data_req_i || busy_i || !ready_ex_i || !ready_wb_i) begin
        ctrl_errs++;
        $display("Error at %0t: outputs not in reset state (req %b busy %b rdy_ex %b rdy_wb %b)",
                 $time, data_req_i, busy_i, ready_ex_i, ready_wb_i);
      end
    end
    was_reset = !rst_n;
    if (!rst_n) begin
      cnt = 0;
      chk_q.delete();
      exp_q.delete();
    end else begin
      size    = ex_req_i.size;
      eff     = ex_req_i.use_incr ? ex_req_i.op_a + ex_req_i.op_b : ex_req_i.op_a;
      off     = eff[1:0];
      second  = ex_req_i.second_phase;
      exp_mis = data_req_ex_i && !second &&
                ((size == 2'b00 && off != 2'b00) || (size == 2'b01 && off == 2'b11));
      if (misaligned_i !== exp_mis) begin
        ctrl_errs++;
        $display("Error at %0t: misaligned %b, expected %b", $time, misaligned_i, exp_mis);
      end
      if (cnt > `LSU_MAX_OUTSTANDING) begin
        ctrl_errs++;
        $display("More than two bus transfers outstanding at time %0t", $time);
      end

      // bus request only below the limit
      exp_req = data_req_ex_i && (cnt < `LSU_MAX_OUTSTANDING);
      exp_acc = exp_req && data_gnt_i;
      if (data_req_i !== exp_req) begin
        ctrl_errs++;
        $display("Error at %0t: bus request %b with %0d outstanding, expected %b",
                 $time, data_req_i, cnt, exp_req);
      end

      // ex ready per outstanding count
      case (cnt)
        0:       exp_rdy = exp_acc;
        1:       exp_rdy = exp_acc && data_rvalid_i;
        default: exp_rdy = data_rvalid_i;
      endcase
      if (!data_req_ex_i) exp_rdy = 1'b1; // idle
      if (ready_ex_i !== exp_rdy) begin
        ctrl_errs++;
        $display("Error at %0t: ex ready %b with %0d outstanding, expected %b",
                 $time, ready_ex_i, cnt, exp_rdy);
      end

      if (busy_i !== (cnt != 0 || data_req_i)) begin
        ctrl_errs++;
        $display("Error at %0t: busy %b with %0d outstanding", $time, busy_i, cnt);
      end
      if (ready_wb_i !== (cnt == 0 || data_rvalid_i)) begin
        ctrl_errs++;
        $display("Error at %0t: wb ready %b with %0d outstanding", $time, ready_wb_i, cnt);
      end

      // compare each accepted bus request and predict its response
      if (data_req_i && data_gnt_i) begin
        exp_addr  = second ? {eff[31:2], 2'b00} : eff;
        exp_be    = expected_be(size, off, second);
        exp_wdata = rotate_store(ex_req_i.wdata, off - ex_req_i.reg_offset);
        if (bus_i.addr !== exp_addr || bus_i.be !== exp_be || bus_i.we !== ex_req_i.we ||
            (ex_req_i.we && bus_i.wdata !== exp_wdata)) begin
          bus_errs++;
          $display("Error at %0t: bus addr %h be %b wdata %h, expected addr %h be %b wdata %h",
                   $time, bus_i.addr, bus_i.be, bus_i.wdata, exp_addr, exp_be, exp_wdata);
        end
        idx = exp_addr[7:2];
        if (ex_req_i.we) begin
          for (int b = 0; b < 4; b++) begin
            if (exp_be[b]) mem[idx][8*b +: 8] = exp_wdata[8*b +: 8];
          end
          chk_q.push_back(1'b0);
          exp_q.push_back('0);
        end else if (exp_mis) begin // value known only after the second word
          first_word = mem[idx];
          first_off  = off;
          first_size = size;
          first_ext  = ex_req_i.ext;
          chk_q.push_back(1'b0);
          exp_q.push_back('0);
        end else if (second) begin
          chk_q.push_back(1'b1);
          exp_q.push_back(load_value({mem[idx], first_word}, first_off, first_size, first_ext));
        end else begin
          chk_q.push_back(1'b1);
          exp_q.push_back(load_value({32'h0, mem[idx]}, off, size, ex_req_i.ext));
        end
        cnt++;
      end

      if (data_rvalid_i) begin
        if (chk_q.size() == 0) begin
          ctrl_errs++;
          $display("Bus response at time %0t with no transfer outstanding", $time);
        end else begin
          chk     = chk_q.pop_front();
          exp_val = exp_q.pop_front();
          if (chk) begin
            loads_checked++;
            if (rdata_ex_i !== exp_val) begin
              load_errs++;
              $display("Error at %0t: load result %h, expected %h", $time, rdata_ex_i, exp_val);
            end
          end
        end
        cnt--;
      end
    end
  end

endmodule

`default_nettype wire

/* tests/tb_lsu.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lsu_params.svh"

module tb_lsu;

  localparam int NUM_ACCESSES   = 400;
  localparam int RESET_CYCLES   = 16;
  localparam int TIMEOUT_CYCLES = NUM_ACCESSES * 2 * 8 + 100; // two phases, 8 cycles each

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic                   data_req_ex;
  lsu_pkg::lsu_ex_req_t   ex_req;
  logic [`LSU_DATA_W-1:0] data_rdata_ex;
  logic                   data_misaligned;
  logic                   lsu_ready_ex;
  logic                   lsu_ready_wb;
  logic                   busy;
  logic                   data_req;
  lsu_pkg::lsu_bus_req_t  bus;
  logic                   data_gnt    = 1'b0;
  logic                   data_rvalid = 1'b0;
  logic [`LSU_DATA_W-1:0] data_rdata  = '0;

  integer seed      = 63;
  int     cycle_cnt = 0;
  int     accesses  = 0;
  int     bus_errs;
  int     load_errs;
  int     ctrl_errs;
  int     loads_checked;

  // bus slave memory, words picked by addr[7:2]
  logic [`LSU_DATA_W-1:0] mem [64];
  logic [`LSU_DATA_W-1:0] resp_q [$]; // read data per accepted transfer, in order
  int                     wait_q [$]; // cycles until each response
  int                     gnt_wait = 0;
  logic [5:0]             idx;

  initial begin
    forever #20 clk = ~clk;
  end

  lsu_top UUT (
    .clk (clk), .rst_n (rst_n),
    .data_req_ex_i (data_req_ex), .ex_req_i (ex_req),
    .data_rdata_ex_o (data_rdata_ex), .data_misaligned_o (data_misaligned),
    .lsu_ready_ex_o (lsu_ready_ex), .lsu_ready_wb_o (lsu_ready_wb), .busy_o (busy),
    .data_req_o (data_req), .bus_o (bus),
    .data_gnt_i (data_gnt), .data_rvalid_i (data_rvalid), .data_rdata_i (data_rdata)
  );

  lsu_checker u_checker (
    .clk (clk), .rst_n (rst_n),
    .data_req_ex_i (data_req_ex), .ex_req_i (ex_req),
    .rdata_ex_i (data_rdata_ex), .misaligned_i (data_misaligned),
    .ready_ex_i (lsu_ready_ex), .ready_wb_i (lsu_ready_wb), .busy_i (busy),
    .data_req_i (data_req), .bus_i (bus), .data_gnt_i (data_gnt), .data_rvalid_i (data_rvalid),
    .bus_errs_o (bus_errs), .load_errs_o (load_errs), .ctrl_errs_o (ctrl_errs),
    .loads_checked_o (loads_checked)
  );

  ////////////////////////////////////////
  // execute stage model
  ////////////////////////////////////////

  function automatic lsu_pkg::lsu_ex_req_t random_access();
    lsu_pkg::lsu_ex_req_t r;
    logic [31:0]          rnd;
    rnd          = $random(seed);
    r            = '0;
    r.we         = rnd[0];
    r.size       = lsu_pkg::lsu_size_e'(rnd[2:1]);
    r.ext        = lsu_pkg::lsu_ext_e'(rnd[4:3]);
    r.reg_offset = rnd[6:5];
    r.use_incr   = rnd[7];
    r.op_a       = {24'h0, rnd[15:8]};                          // small window
    r.op_b       = rnd[7] ? {28'h0, rnd[19:16]} : $random(seed); // b unused without incr
    r.wdata      = $random(seed);
    return r;
  endfunction

  // hold the request until the unit takes it, report crossing at that edge
  task automatic present_access(input lsu_pkg::lsu_ex_req_t r, output logic misaligned);
    data_req_ex <= 1'b1;
    ex_req      <= r;
    @(posedge clk);
    while (!lsu_ready_ex) @(posedge clk);
    misaligned = data_misaligned;
  endtask

  initial begin
    lsu_pkg::lsu_ex_req_t   req;
    logic                   misaligned;
    logic [`LSU_DATA_W-1:0] eff;
    logic [31:0]            idle_rnd;
    rst_n       = 1'b0;
    data_req_ex = 1'b0;
    ex_req      = '0;
    for (int i = 0; i < 64; i++) mem[i] = (i * 32'h0101_0101) ^ 32'h5A3C_96E1 ^ (i << 20);
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);
    for (int n = 0; n < NUM_ACCESSES; n++) begin
      req = random_access();
      present_access(req, misaligned);
      if (misaligned) begin // next word of the same access
        eff               = req.use_incr ? req.op_a + req.op_b : req.op_a;
        req.op_a          = eff + 32'd4;
        req.use_incr      = 1'b0;
        req.second_phase  = 1'b1;
        present_access(req, misaligned);
      end
      accesses++;
      idle_rnd = $random(seed);
      if (idle_rnd[1:0] == 2'b00) begin
        data_req_ex <= 1'b0; // bubble
        @(posedge clk);
      end
    end
    data_req_ex <= 1'b0;
    @(posedge clk);
    while (busy) @(posedge clk); // drain outstanding responses
    repeat (2) @(posedge clk);
    $display("summary: %0d accesses, %0d loads checked, errors bus %0d load %0d control %0d",
             accesses, loads_checked, bus_errs, load_errs, ctrl_errs);
    if (bus_errs + load_errs + ctrl_errs == 0 && loads_checked > 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  ////////////////////////////////////////
  // bus responder
  ////////////////////////////////////////

  always @(posedge clk) begin
    if (!rst_n) begin
      data_gnt    <= 1'b0;
      data_rvalid <= 1'b0;
      gnt_wait    = 0;
      resp_q.delete();
      wait_q.delete();
    end else begin
      if (data_req && data_gnt) begin
        idx = bus.addr[7:2];
        for (int b = 0; b < 4; b++) begin
          if (bus.we && bus.be[b]) mem[idx][8*b +: 8] = bus.wdata[8*b +: 8];
        end
        resp_q.push_back(mem[idx]);
        wait_q.push_back(1 + $unsigned($random(seed)) % 3); // 1 to 3 cycles
        gnt_wait = $unsigned($random(seed)) % 3;            // next grant 0 to 2 late
      end else if (data_req && gnt_wait > 0) begin
        gnt_wait--;
      end
      data_gnt    <= (gnt_wait == 0);
      data_rvalid <= 1'b0;
      if (resp_q.size() > 0) begin // answer in order
        if (wait_q[0] <= 1) begin
          data_rvalid <= 1'b1;
          data_rdata  <= resp_q.pop_front();
          void'(wait_q.pop_front());
        end else begin
          wait_q[0] = wait_q[0] - 1;
        end
      end
    end
  end

  // run limit
  initial begin
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire
